//--- Makefile
SIM := obj_dir/Vtb_fmap_window_reader

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

$(SIM): list.f $(shell cat list.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fmap_window_reader -f list.f

clean:
	rm -rf obj_dir

//--- list.f
src/fmap_win_pkg.sv
src/scan_ctrl.sv
src/bank_addr_gen.sv
src/window_assemble.sv
src/fmap_window_reader.sv
verif/tb_fmap_window_reader.sv

//--- src/bank_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module bank_addr_gen #(
	parameter int IMG_ROWS = fmap_win_pkg::DEF_IMG_ROWS,
	parameter int IMG_COLS = fmap_win_pkg::DEF_IMG_COLS
) (
	input  wire                     clk,
	input  wire                     rstn,
	input  wire fmap_win_pkg::scan_pos_t pos,
	input  wire                     pos_valid,
	output fmap_win_pkg::bank_req_t req
);

	localparam int GRID_W        = fmap_win_pkg::GRID_W;
	localparam int PIX_W         = fmap_win_pkg::POS_W + 1;
	localparam int WORDS_PER_ROW = IMG_COLS / fmap_win_pkg::BANK_GRID;
	localparam int WORD_ROWS     = (IMG_ROWS + fmap_win_pkg::BANK_GRID - 1) /
	                               fmap_win_pkg::BANK_GRID;
	localparam int ADDR_LIMIT    = WORD_ROWS * WORDS_PER_ROW;

	logic [fmap_win_pkg::NUM_BANKS-1:0][GRID_W-1:0] row_ofs, col_ofs;
	logic [fmap_win_pkg::NUM_BANKS-1:0][PIX_W-1:0] pix_y, pix_x;   // pixel coord plus one
	logic [fmap_win_pkg::NUM_BANKS-1:0] in_img;
	fmap_win_pkg::bank_req_t req_d;

	////////////////////////////////////////////////////////////////////////////
	// each bank serves exactly one pixel of the 4x4 window
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		req_d = '0;
		for (int b = 0; b < fmap_win_pkg::NUM_BANKS; b++) begin
			// window offset whose residue matches this bank
			row_ofs[b] = GRID_W'(b / fmap_win_pkg::BANK_GRID + 1) - pos.row[GRID_W-1:0];
			col_ofs[b] = GRID_W'(b % fmap_win_pkg::BANK_GRID + 1) - pos.col[GRID_W-1:0];
			pix_y[b]   = {1'b0, pos.row} + PIX_W'(row_ofs[b]);
			pix_x[b]   = {1'b0, pos.col} + PIX_W'(col_ofs[b]);
			in_img[b]  = pos_valid &&
			             (pix_y[b] != '0) && (pix_y[b] <= PIX_W'(IMG_ROWS)) &&
			             (pix_x[b] != '0) && (pix_x[b] <= PIX_W'(IMG_COLS));
			req_d.cs[b] = in_img[b];
			if (in_img[b]) begin
				req_d.addr[b] = fmap_win_pkg::ADDR_W'(
					((pix_y[b] - 1'b1) >> GRID_W) * WORDS_PER_ROW +
					((pix_x[b] - 1'b1) >> GRID_W));
			end
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			req <= '0;
		end else begin
			req <= req_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	for (genvar gb = 0; gb < fmap_win_pkg::NUM_BANKS; gb++) begin : g_chk
		a_addr_range: assert property (@(posedge clk) disable iff (!rstn)
			req.cs[gb] |-> req.addr[gb] < ADDR_LIMIT);
	end

endmodule

`default_nettype wire

//--- src/fmap_win_pkg.sv
`default_nettype none

package fmap_win_pkg;

	////////////////////////////////////////////////////////////////////////////
	// geometry of the bank array and the window
	////////////////////////////////////////////////////////////////////////////
	localparam int NUM_BANKS = 16;
	localparam int BANK_GRID = 4;                    // banks per row and per column
	localparam int GRID_W    = $clog2(BANK_GRID);
	localparam int CHANNELS  = 4;
	localparam int BYTE_W    = 8;
	localparam int SLICE_W   = $clog2(CHANNELS);
	localparam int ADDR_W    = 9;
	localparam int POS_W     = 8;                    // row and col counters

	// defaults for the top level parameters
	localparam int DEF_IMG_ROWS     = 128;
	localparam int DEF_IMG_COLS     = 128;
	localparam int DEF_WINDOW_DELAY = 20;
	localparam int DEF_ROW_GAP      = 63;

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	// one bank word, one pixel with all its channels
	typedef union packed {
		logic [CHANNELS*BYTE_W-1:0]         raw;
		logic [CHANNELS-1:0][BYTE_W-1:0]    chans;   // chans[0] is channel 0
	} bank_word_u;

	typedef struct packed {
		logic [POS_W-1:0] row;
		logic [POS_W-1:0] col;
	} scan_pos_t;

	typedef struct packed {
		logic               beat;                    // mac beat this cycle
		logic [SLICE_W-1:0] slice;                   // channel of the beat
	} scan_phase_t;

	typedef struct packed {
		logic [NUM_BANKS-1:0]             cs;
		logic [NUM_BANKS-1:0][ADDR_W-1:0] addr;      // indexed by bank
	} bank_req_t;

	typedef bank_word_u [NUM_BANKS-1:0] bank_rdata_t;

	typedef logic [NUM_BANKS-1:0][BYTE_W-1:0] win_lanes_t;   // lane 4r + c

	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_row_gap
	} scan_state_e;

endpackage

`default_nettype wire

//--- src/fmap_window_reader.sv
`timescale 1ns/1ps
`default_nettype none

module fmap_window_reader #(
	parameter int IMG_ROWS     = fmap_win_pkg::DEF_IMG_ROWS,
	parameter int IMG_COLS     = fmap_win_pkg::DEF_IMG_COLS,
	parameter int WINDOW_DELAY = fmap_win_pkg::DEF_WINDOW_DELAY,
	parameter int ROW_GAP      = fmap_win_pkg::DEF_ROW_GAP
) (
	input  wire                            clk,
	input  wire                            rstn,
	input  wire                            start,
	input  wire fmap_win_pkg::bank_rdata_t rdata,    // one cycle after req
	output fmap_win_pkg::bank_req_t        req,
	output fmap_win_pkg::win_lanes_t       lanes,
	output logic                           mac_vld
);

	fmap_win_pkg::scan_pos_t   pos;
	fmap_win_pkg::scan_phase_t phase;
	logic                      pos_valid;

	scan_ctrl #(
		.IMG_ROWS     (IMG_ROWS),
		.IMG_COLS     (IMG_COLS),
		.WINDOW_DELAY (WINDOW_DELAY),
		.ROW_GAP      (ROW_GAP)
	) i_scan_ctrl (
		.clk          (clk),
		.rstn         (rstn),
		.start        (start),
		.pos          (pos),
		.pos_valid    (pos_valid),
		.phase        (phase)
	);

	bank_addr_gen #(
		.IMG_ROWS     (IMG_ROWS),
		.IMG_COLS     (IMG_COLS)
	) i_bank_addr_gen (
		.clk          (clk),
		.rstn         (rstn),
		.pos          (pos),
		.pos_valid    (pos_valid),
		.req          (req)
	);

	window_assemble #(
		.IMG_ROWS     (IMG_ROWS),
		.IMG_COLS     (IMG_COLS)
	) i_window_assemble (
		.clk          (clk),
		.rstn         (rstn),
		.rdata        (rdata),
		.pos          (pos),
		.phase        (phase),
		.lanes        (lanes),
		.mac_vld      (mac_vld)
	);

endmodule

`default_nettype wire

//--- src/scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl #(
	parameter int IMG_ROWS     = fmap_win_pkg::DEF_IMG_ROWS,
	parameter int IMG_COLS     = fmap_win_pkg::DEF_IMG_COLS,
	parameter int WINDOW_DELAY = fmap_win_pkg::DEF_WINDOW_DELAY,
	parameter int ROW_GAP      = fmap_win_pkg::DEF_ROW_GAP
) (
	input  wire                       clk,
	input  wire                       rstn,
	input  wire                       start,
	output fmap_win_pkg::scan_pos_t   pos,
	output logic                      pos_valid,
	output fmap_win_pkg::scan_phase_t phase
);

	localparam int DWELL_W    = $clog2(WINDOW_DELAY);
	localparam int GAP_W      = $clog2(ROW_GAP + 1);
	localparam int BEAT_START = WINDOW_DELAY - fmap_win_pkg::CHANNELS;

	fmap_win_pkg::scan_state_e state, state_d;
	logic [fmap_win_pkg::POS_W-1:0] row_d, col_d;
	logic [DWELL_W-1:0] dwell, dwell_d;
	logic [GAP_W-1:0] gap, gap_d;
	logic dwell_last, gap_last, col_last, row_last;
	logic beat_d;
	logic [fmap_win_pkg::SLICE_W-1:0] slice_d;

	assign dwell_last = (dwell == DWELL_W'(WINDOW_DELAY - 1));
	assign gap_last   = (gap == GAP_W'(ROW_GAP - 1));
	assign col_last   = (pos.col == fmap_win_pkg::POS_W'(IMG_COLS - 1));
	assign row_last   = (pos.row == fmap_win_pkg::POS_W'(IMG_ROWS - 1));
	assign pos_valid  = (state == fmap_win_pkg::st_scan);

	////////////////////////////////////////////////////////////////////////////
	// next state and counters
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		state_d = state;
		row_d   = pos.row;
		col_d   = pos.col;
		dwell_d = dwell;
		gap_d   = gap;
		case (state)
			fmap_win_pkg::st_idle: begin
				if (start) begin                         // first window at (0, 0)
					state_d = fmap_win_pkg::st_scan;
					row_d   = '0;
					col_d   = '0;
					dwell_d = '0;
				end
			end
			fmap_win_pkg::st_scan: begin
				if (dwell_last) begin
					dwell_d = '0;
					if (!col_last) begin
						col_d = pos.col + 1'b1;
					end else begin
						col_d = '0;
						if (row_last) begin              // whole image done
							state_d = fmap_win_pkg::st_idle;
							row_d   = '0;
						end else begin
							state_d = fmap_win_pkg::st_row_gap;
							row_d   = pos.row + 1'b1;
							gap_d   = '0;
						end
					end
				end else begin
					dwell_d = dwell + 1'b1;
				end
			end
			fmap_win_pkg::st_row_gap: begin
				if (gap_last) begin
					state_d = fmap_win_pkg::st_scan;
				end else begin
					gap_d = gap + 1'b1;
				end
			end
			default: state_d = fmap_win_pkg::st_idle;
		endcase
	end

	// beats occupy the last CHANNELS cycles of the dwell
	assign beat_d  = (state_d == fmap_win_pkg::st_scan) && (dwell_d >= DWELL_W'(BEAT_START));
	assign slice_d = beat_d ? fmap_win_pkg::SLICE_W'(dwell_d - DWELL_W'(BEAT_START)) : '0;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= fmap_win_pkg::st_idle;
			pos   <= '0;
			dwell <= '0;
			gap   <= '0;
			phase <= '0;
		end else begin
			state       <= state_d;
			pos.row     <= row_d;
			pos.col     <= col_d;
			dwell       <= dwell_d;
			gap         <= gap_d;
			phase.beat  <= beat_d;
			phase.slice <= slice_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	a_beat_in_scan: assert property (@(posedge clk) disable iff (!rstn)
		phase.beat |-> state == fmap_win_pkg::st_scan);

	a_pos_in_image: assert property (@(posedge clk) disable iff (!rstn)
		state == fmap_win_pkg::st_scan |-> (pos.row < IMG_ROWS) && (pos.col < IMG_COLS));

	// one burst of channel beats per window
	a_beat_burst: assert property (@(posedge clk) disable iff (!rstn)
		$rose(phase.beat) |-> phase.beat [*fmap_win_pkg::CHANNELS] ##1 !phase.beat);

endmodule

`default_nettype wire

//--- src/window_assemble.sv
`timescale 1ns/1ps
`default_nettype none

module window_assemble #(
	parameter int IMG_ROWS = fmap_win_pkg::DEF_IMG_ROWS,
	parameter int IMG_COLS = fmap_win_pkg::DEF_IMG_COLS
) (
	input  wire                            clk,
	input  wire                            rstn,
	input  wire fmap_win_pkg::bank_rdata_t rdata,
	input  wire fmap_win_pkg::scan_pos_t   pos,
	input  wire fmap_win_pkg::scan_phase_t phase,
	output fmap_win_pkg::win_lanes_t       lanes,
	output logic                           mac_vld
);

	localparam int GRID_W = fmap_win_pkg::GRID_W;
	localparam int PIX_W  = fmap_win_pkg::POS_W + 1;

	fmap_win_pkg::bank_rdata_t cap;                  // words from the banks
	fmap_win_pkg::scan_pos_t   pos_q;
	fmap_win_pkg::scan_phase_t phase_q;
	logic [fmap_win_pkg::NUM_BANKS-1:0][GRID_W-1:0] row_res, col_res;
	logic [fmap_win_pkg::NUM_BANKS-1:0][2*GRID_W-1:0] lane_bank;
	logic [fmap_win_pkg::NUM_BANKS-1:0][PIX_W-1:0] pix_y, pix_x;
	logic [fmap_win_pkg::NUM_BANKS-1:0] lane_in;
	fmap_win_pkg::win_lanes_t lanes_d;

	////////////////////////////////////////////////////////////////////////////
	// capture stage
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		for (int b = 0; b < fmap_win_pkg::NUM_BANKS; b++) begin
			cap[b].raw <= rdata[b].raw;
		end
	end

	// position and phase follow the data by one cycle
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pos_q   <= '0;
			phase_q <= '0;
		end else begin
			pos_q   <= pos;
			phase_q <= phase;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bank to lane mapping and edge padding
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		fmap_win_pkg::bank_word_u word;
		lanes_d = '0;
		for (int l = 0; l < fmap_win_pkg::NUM_BANKS; l++) begin
			// residues of pixel (row - 1 + r, col - 1 + c)
			row_res[l] = pos_q.row[GRID_W-1:0] + GRID_W'(l / fmap_win_pkg::BANK_GRID) -
			             GRID_W'(1);
			col_res[l] = pos_q.col[GRID_W-1:0] + GRID_W'(l % fmap_win_pkg::BANK_GRID) -
			             GRID_W'(1);
			lane_bank[l] = {row_res[l], col_res[l]};
			pix_y[l]   = {1'b0, pos_q.row} + PIX_W'(l / fmap_win_pkg::BANK_GRID);
			pix_x[l]   = {1'b0, pos_q.col} + PIX_W'(l % fmap_win_pkg::BANK_GRID);
			lane_in[l] = (pix_y[l] != '0) && (pix_y[l] <= PIX_W'(IMG_ROWS)) &&
			             (pix_x[l] != '0) && (pix_x[l] <= PIX_W'(IMG_COLS));
			word = cap[lane_bank[l]];
			if (lane_in[l]) begin
				lanes_d[l] = word.chans[phase_q.slice];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (phase_q.beat) begin
			lanes <= lanes_d;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			mac_vld <= 1'b0;
		end else begin
			mac_vld <= phase_q.beat;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	for (genvar gl = 0; gl < fmap_win_pkg::NUM_BANKS; gl++) begin : g_chk
		localparam int LR = gl / fmap_win_pkg::BANK_GRID;
		localparam int LC = gl % fmap_win_pkg::BANK_GRID;
		// lanes on a beat belong to the position of the cycle before
		a_pad_zero: assert property (@(posedge clk) disable iff (!rstn)
			mac_vld && ((int'($past(pos_q.row)) + LR - 1 < 0) ||
			            (int'($past(pos_q.row)) + LR - 1 >= IMG_ROWS) ||
			            (int'($past(pos_q.col)) + LC - 1 < 0) ||
			            (int'($past(pos_q.col)) + LC - 1 >= IMG_COLS))
			|-> lanes[gl] == '0);
	end

endmodule

`default_nettype wire

//--- verif/fmap_trace.txt
# M bank addr word   memory image, word in hex with channel 0 in the low byte
# W row col lane0 .. lane15   expected channel 0 window in hex
M 0 0 C1814101
M 1 0 C2824202
M 2 0 C3834303
M 3 0 C4844404
M 0 1 C5854505
M 1 1 C6864606
M 2 1 C7874707
M 3 1 C8884808
M 4 0 C9894909
M 5 0 CA8A4A0A
M 6 0 CB8B4B0B
M 7 0 CC8C4C0C
M 4 1 CD8D4D0D
M 5 1 CE8E4E0E
M 6 1 CF8F4F0F
M 7 1 D0905010
W 0 0 00 00 00 00 00 01 02 03 00 09 0a 0b 00 00 00 00
W 0 1 00 00 00 00 01 02 03 04 09 0a 0b 0c 00 00 00 00
W 0 2 00 00 00 00 02 03 04 05 0a 0b 0c 0d 00 00 00 00
W 0 3 00 00 00 00 03 04 05 06 0b 0c 0d 0e 00 00 00 00
W 0 4 00 00 00 00 04 05 06 07 0c 0d 0e 0f 00 00 00 00
W 0 5 00 00 00 00 05 06 07 08 0d 0e 0f 10 00 00 00 00
W 0 6 00 00 00 00 06 07 08 00 0e 0f 10 00 00 00 00 00
W 0 7 00 00 00 00 07 08 00 00 0f 10 00 00 00 00 00 00
W 1 0 00 01 02 03 00 09 0a 0b 00 00 00 00 00 00 00 00
W 1 1 01 02 03 04 09 0a 0b 0c 00 00 00 00 00 00 00 00
W 1 2 02 03 04 05 0a 0b 0c 0d 00 00 00 00 00 00 00 00
W 1 3 03 04 05 06 0b 0c 0d 0e 00 00 00 00 00 00 00 00
W 1 4 04 05 06 07 0c 0d 0e 0f 00 00 00 00 00 00 00 00
W 1 5 05 06 07 08 0d 0e 0f 10 00 00 00 00 00 00 00 00
W 1 6 06 07 08 00 0e 0f 10 00 00 00 00 00 00 00 00 00
W 1 7 07 08 00 00 0f 10 00 00 00 00 00 00 00 00 00 00

//--- verif/tb_fmap_window_reader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fmap_window_reader;

	localparam int ROWS    = 2;
	localparam int COLS    = 8;
	localparam int NPOS    = ROWS * COLS;
	localparam int NB      = fmap_win_pkg::NUM_BANKS;
	localparam int DEPTH   = 2 ** fmap_win_pkg::ADDR_W;
	localparam int TIMEOUT = 100;                    // cycles per wait

	logic clk;
	logic rstn;
	logic start;
	fmap_win_pkg::bank_rdata_t rdata;
	fmap_win_pkg::bank_req_t   req;
	fmap_win_pkg::win_lanes_t  lanes;
	logic                      mac_vld;

	logic [31:0] mem [NB][DEPTH];
	logic [7:0]  win0 [NPOS][NB];                    // channel 0 windows from the trace
	int          fails [6];
	string       test_name [6] = '{"reset state", "channel 0", "channel slicing",
		"chip selects and addresses", "beat counts", "restart"};

	fmap_window_reader #(
		.IMG_ROWS     (ROWS),
		.IMG_COLS     (COLS),
		.WINDOW_DELAY (8),
		.ROW_GAP      (5)
	) i_dut (
		.clk     (clk),
		.rstn    (rstn),
		.start   (start),
		.rdata   (rdata),
		.req     (req),
		.lanes   (lanes),
		.mac_vld (mac_vld)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// bank memory model with one cycle read latency
	always @(posedge clk) begin
		for (int b = 0; b < NB; b++) begin
			rdata[b].raw <= req.cs[b] ? mem[b][req.addr[b]] : $urandom;   // noise when idle
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic check_val(input int t, input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			fails[t]++;
			$display("Mismatch at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic wait_beat(output int low, output bit ok);
		low = 0;
		@(negedge clk);
		while (!mac_vld && low < TIMEOUT) begin
			low++;
			@(negedge clk);
		end
		ok = mac_vld;
	endtask

	// lanes and bank requests against the storage rule at position p, beat s
	task automatic verify_window(input int p, input int s, input int t_lane, input int t_req);
		int y;
		int x;
		int bank;
		int addr;
		logic [7:0] want;
		logic [NB-1:0] cs_want;
		cs_want = '0;
		for (int l = 0; l < NB; l++) begin
			y    = p / COLS - 1 + l / 4;
			x    = p % COLS - 1 + l % 4;
			want = 8'h00;
			if (y >= 0 && y < ROWS && x >= 0 && x < COLS) begin
				bank = (y % 4) * 4 + x % 4;
				addr = (y / 4) * (COLS / 4) + x / 4;
				want = mem[bank][addr][8*s +: 8];
				cs_want[bank] = 1'b1;
				if (s == 0) begin
					check_val(t_req, req.addr[bank], addr,
						$sformatf("pos %0d bank %0d address", p, bank));
				end
			end
			check_val(t_lane, lanes[l], want, $sformatf("pos %0d beat %0d lane %0d", p, s, l));
		end
		if (s == 0) begin
			check_val(t_req, req.cs, cs_want, $sformatf("pos %0d chip selects", p));
		end
	endtask

	task automatic report_test(input int t);
		if (fails[t] == 0) begin
			$display("test %0d, %s: passed", t + 1, test_name[t]);
		end else begin
			$display("test %0d, %s: failed with %0d errors", t + 1, test_name[t], fails[t]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// trace and scans
	////////////////////////////////////////////////////////////////////////////
	task automatic load_trace();
		int fd;
		int n;
		int b;
		int a;
		int r;
		int c;
		int m_lines;
		int w_lines;
		logic [31:0] word;
		logic [7:0] v [NB];
		string line;
		m_lines = 0;
		w_lines = 0;
		fd = $fopen("verif/fmap_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file verif/fmap_trace.txt");
			fails[1]++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			if (line.getc(0) == "M" && $sscanf(line, "M %d %d %h", b, a, word) == 3) begin
				mem[b][a] = word;
				m_lines++;
			end else if (line.getc(0) == "W") begin
				n = $sscanf(line, "W %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					r, c, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
					v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
				if (n == 18) begin
					for (int l = 0; l < NB; l++) begin
						win0[r * COLS + c][l] = v[l];
					end
					w_lines++;
				end
			end
		end
		$fclose(fd);
		if (m_lines != 16 || w_lines != NPOS) begin
			$display("trace file holds %0d memory lines and %0d window lines, not 16 and %0d",
				m_lines, w_lines, NPOS);
			fails[1]++;
		end
	endtask

	task automatic run_scan(input bit again);
		int low;
		int beats;
		bit ok;
		int t_ch0;
		int t_slice;
		int t_req;
		int t_cnt;
		t_ch0   = again ? 5 : 1;
		t_slice = again ? 5 : 2;
		t_req   = again ? 5 : 3;
		t_cnt   = again ? 5 : 4;
		beats   = 0;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		for (int p = 0; p < NPOS; p++) begin
			wait_beat(low, ok);
			if (!ok) begin
				$display("timeout: no mac_vld beat for position %0d in %0d cycles", p, TIMEOUT);
				fails[t_cnt]++;
				break;
			end
			check_val(t_cnt, low > 0, 1, $sformatf("mac_vld low before position %0d", p));
			if (p == COLS) begin
				check_val(t_cnt, low >= 5, 1, "gap of 5 cycles between row 0 and row 1");
			end
			for (int s = 0; s < fmap_win_pkg::CHANNELS; s++) begin
				if (s > 0) begin
					@(negedge clk);
				end
				beats += mac_vld;
				check_val(t_cnt, mac_vld, 1, $sformatf("mac_vld on beat %0d of pos %0d", s, p));
				verify_window(p, s, t_slice, t_req);
				if (s == 0) begin
					for (int l = 0; l < NB; l++) begin
						check_val(t_ch0, lanes[l], win0[p][l],
							$sformatf("pos %0d lane %0d against trace", p, l));
					end
				end
			end
		end
		repeat (40) begin                            // scan must be idle now
			@(negedge clk);
			beats += mac_vld;
		end
		check_val(t_cnt, beats, NPOS * fmap_win_pkg::CHANNELS, "total number of beats");
	endtask

	initial begin
		int errors;
		int failed;
		errors = 0;
		failed = 0;
		rstn   <= 1'b0;
		start  <= 1'b0;
		rdata  <= '0;
		void'($urandom(63));
		for (int b = 0; b < NB; b++) begin
			for (int a = 0; a < DEPTH; a++) begin
				mem[b][a] = $urandom;
			end
		end
		load_trace();
		repeat (3) @(posedge clk);
		rstn <= 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			check_val(0, mac_vld, 0, "mac_vld before start");
			check_val(0, req.cs, 0, "chip selects before start");
			check_val(0, req.addr == '0, 1, "addresses before start");
		end
		report_test(0);
		run_scan(1'b0);
		for (int t = 1; t < 5; t++) begin
			report_test(t);
		end
		run_scan(1'b1);
		report_test(5);
		foreach (fails[t]) begin
			errors += fails[t];
			failed += (fails[t] != 0);
		end
		$display("tests: %0d passed, %0d failed, %0d errors", 6 - failed, failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
